/* Makefile */
TOP = tb_mod_inv

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* inv_control.sv */
`timescale 1ns/1ps

module inv_control (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  inv_pkg::flags_t flags,
  input  logic            last,
  output logic            busy,
  output logic            done,
  output logic            load,
  output logic            advance,
  output logic            capture,
  output logic            clear,
  output logic            incr,
  output inv_pkg::step_t  step
);

  inv_pkg::state_t state;
  inv_pkg::state_t state_n;
  inv_pkg::step_t  step_n;
  logic            accept;

  // start counts only in idle and not in the done cycle
  assign accept = (state == inv_pkg::idle) && start && !done;

  always_comb begin
    state_n = state;
    case (state)
      inv_pkg::idle: begin
        if (accept) begin
          state_n = inv_pkg::load;
        end
      end
      inv_pkg::load: begin
        state_n = inv_pkg::classify;
      end
      inv_pkg::classify: begin
        state_n = inv_pkg::apply;
      end
      inv_pkg::apply: begin
        state_n = last ? inv_pkg::finish : inv_pkg::classify;
      end
      inv_pkg::finish: begin
        state_n = inv_pkg::idle;
      end
      default: begin
        state_n = inv_pkg::idle;
      end
    endcase
  end

  // case selection, same priority as the BEEA loop body
  always_comb begin
    if (!flags.v_zero) begin
      if (flags.u_even) begin
        step_n = inv_pkg::halve_u;
      end else if (flags.v_even) begin
        step_n = inv_pkg::halve_v;
      end else if (flags.u_gt_v) begin
        step_n = inv_pkg::sub_u;
      end else begin
        step_n = inv_pkg::sub_v;
      end
    end else begin
      // v reached zero, only r needs its sign fixed
      step_n = flags.r_neg ? inv_pkg::fix_neg : inv_pkg::fix_keep;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= inv_pkg::idle;
      step  <= inv_pkg::fix_keep;
      done  <= 1'b0;
    end else begin
      state <= state_n;
      if (state == inv_pkg::classify) begin
        step <= step_n;
      end
      done <= (state == inv_pkg::finish);
    end
  end

  // operands are sampled on the edge that accepts start
  assign load    = accept;
  assign clear   = (state == inv_pkg::load);
  assign advance = (state == inv_pkg::apply);
  assign incr    = (state == inv_pkg::apply);
  assign capture = (state == inv_pkg::finish);
  assign busy    = (state != inv_pkg::idle) || done;

  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset)
    done |=> !done
  ) else $error("done held longer than one cycle");

  // fix steps only once v is zero, subtracts only with both operands odd
  a_step_defined: assert property (
    @(posedge clk) disable iff (reset)
    (state == inv_pkg::apply) |->
      (((step inside {inv_pkg::fix_neg, inv_pkg::fix_keep}) == flags.v_zero) &&
       (!(step inside {inv_pkg::sub_u, inv_pkg::sub_v}) ||
        (!flags.u_even && !flags.v_even)))
  ) else $error("apply entered with a step that does not fit the operands");

endmodule

/* inv_iter_counter.sv */
`timescale 1ns/1ps

module inv_iter_counter (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic incr,
  output logic last
);

  inv_pkg::iter_t count;

  // cleared during load, one increment per apply
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (incr) begin
      count <= count + 1'b1;
    end
  end

  // count holds the number of finished iterations
  assign last = (count == inv_pkg::iter_t'(inv_pkg::iter_count - 1));

  // controller must stop incrementing once the last iteration is done
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset)
    incr |-> (count < inv_pkg::iter_t'(inv_pkg::iter_count))
  ) else $error("iteration counter incremented past the last iteration");

endmodule

/* inv_operand_regs.sv */
`timescale 1ns/1ps

module inv_operand_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               advance,
  input  logic               capture,
  input  logic               mont,
  input  inv_pkg::word_t     operand,
  input  inv_pkg::operands_t next_ops,
  output inv_pkg::operands_t ops,
  output inv_pkg::word_t     result
);

  // working registers u, v, r, s
  always_ff @(posedge clk) begin
    if (load) begin
      ops.u <= inv_pkg::prime;
      ops.v <= operand;
      ops.r <= '0;
      // montgomery mode folds the 2^256 factor in through s
      if (mont) begin
        ops.s <= inv_pkg::sword_t'(inv_pkg::mont_adjust);
      end else begin
        ops.s <= inv_pkg::sword_t'(1);
      end
    end else if (advance) begin
      ops <= next_ops;
    end
  end

  // r is in [0, p) after the fix steps, so its low word is the result
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (capture) begin
      result <= ops.r[inv_pkg::word_w-1:0];
    end
  end

  // u starts at p and only ever drops to the gcd, never to zero
  a_u_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    advance |-> (ops.u != '0)
  ) else $error("u reached zero during the inversion");

endmodule

/* inv_pkg.sv */
package inv_pkg;

  // operand width and the signed width used for r and s
  localparam int word_w = 256;
  localparam int sword_w = word_w + 2;

  typedef logic [word_w-1:0] word_t;

  // r and s swing through (-2p, 2p) inside a step, so two extra bits
  typedef logic signed [sword_w-1:0] sword_t;

  // p = 2^256 - 2^32 - 977
  localparam word_t prime =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // 2^256 mod p, loaded into s in montgomery mode
  localparam word_t mont_adjust = 256'h1_000003D1;

  // prime widened for the signed r/s arithmetic
  localparam sword_t prime_s = sword_t'(prime);

  // two iterations per operand bit, whatever the operand
  localparam int iter_count = 2 * word_w;
  localparam int iter_w = $clog2(iter_count + 1);

  typedef logic [iter_w-1:0] iter_t;

  typedef enum logic [2:0] {
    idle,
    load,
    classify,
    apply,
    finish
  } state_t;

  typedef enum logic [2:0] {
    halve_u,
    halve_v,
    sub_u,
    sub_v,
    fix_neg,
    fix_keep
  } step_t;

  typedef struct packed {
    word_t  u;
    word_t  v;
    sword_t r;
    sword_t s;
  } operands_t;

  typedef struct packed {
    logic v_zero;
    logic u_even;
    logic v_even;
    logic u_gt_v;
    logic r_neg;
  } flags_t;

endpackage

/* inv_step_unit.sv */
`timescale 1ns/1ps

module inv_step_unit (
  input  inv_pkg::operands_t ops,
  input  inv_pkg::step_t     step,
  output inv_pkg::operands_t next_ops,
  output inv_pkg::flags_t    flags
);

  // bring a value in (-2p, 2p) back into (-p, p)
  function automatic inv_pkg::sword_t reduce(input inv_pkg::sword_t x);
    if (x >= inv_pkg::prime_s) begin
      reduce = x - inv_pkg::prime_s;
    end else if (x <= -inv_pkg::prime_s) begin
      reduce = x + inv_pkg::prime_s;
    end else begin
      reduce = x;
    end
  endfunction

  // x / 2 mod p, odd values first moved toward zero by p
  function automatic inv_pkg::sword_t halve_mod(input inv_pkg::sword_t x);
    inv_pkg::sword_t y;
    if (!x[0]) begin
      y = x;
    end else if (x[inv_pkg::sword_w-1]) begin
      y = x + inv_pkg::prime_s;
    end else begin
      y = x - inv_pkg::prime_s;
    end
    halve_mod = y >>> 1;
  endfunction

  function automatic logic in_range(input inv_pkg::sword_t x);
    in_range = (x > -inv_pkg::prime_s) && (x < inv_pkg::prime_s);
  endfunction

  always_comb begin
    flags.v_zero = (ops.v == '0);
    flags.u_even = !ops.u[0];
    flags.v_even = !ops.v[0];
    flags.u_gt_v = (ops.u > ops.v);
    flags.r_neg  = ops.r[inv_pkg::sword_w-1];
  end

  always_comb begin
    next_ops = ops;
    case (step)
      inv_pkg::halve_u: begin
        next_ops.u = ops.u >> 1;
        next_ops.r = halve_mod(ops.r);
      end
      inv_pkg::halve_v: begin
        next_ops.v = ops.v >> 1;
        next_ops.s = halve_mod(ops.s);
      end
      inv_pkg::sub_u: begin
        // both odd and u > v, so the difference is even and positive
        next_ops.u = (ops.u - ops.v) >> 1;
        next_ops.r = halve_mod(reduce(ops.r - ops.s));
      end
      inv_pkg::sub_v: begin
        next_ops.v = (ops.v - ops.u) >> 1;
        next_ops.s = halve_mod(reduce(ops.s - ops.r));
      end
      inv_pkg::fix_neg: begin
        // only a negative r is lifted by p, so a held step keeps r in range
        if (ops.r[inv_pkg::sword_w-1]) begin
          next_ops.r = ops.r + inv_pkg::prime_s;
        end
      end
      default: begin
        // fix_keep, v is zero and r already non-negative
        next_ops = ops;
      end
    endcase
  end

  // r and s stay inside (-p, p) across every step of the run
  always_comb begin
    if (!$isunknown(next_ops)) begin
      a_rs_bound: assert (in_range(next_ops.r) && in_range(next_ops.s))
        else $error("step unit drove r or s outside (-p, p)");
    end
  end

endmodule

/* mod_inv.sv */
`timescale 1ns/1ps

module mod_inv (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  logic           mont,
  input  inv_pkg::word_t operand,
  output logic           busy,
  output logic           done,
  output inv_pkg::word_t result
);

  inv_pkg::operands_t ops;
  inv_pkg::operands_t next_ops;
  inv_pkg::flags_t    flags;
  inv_pkg::step_t     step;
  logic               load;
  logic               advance;
  logic               capture;
  logic               clear;
  logic               incr;
  logic               last;

  inv_control inv_control_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .flags   (flags),
    .last    (last),
    .busy    (busy),
    .done    (done),
    .load    (load),
    .advance (advance),
    .capture (capture),
    .clear   (clear),
    .incr    (incr),
    .step    (step)
  );

  inv_iter_counter inv_iter_counter_i (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .incr  (incr),
    .last  (last)
  );

  // zero latency, result lands in the registers at the end of apply
  inv_step_unit inv_step_unit_i (
    .ops      (ops),
    .step     (step),
    .next_ops (next_ops),
    .flags    (flags)
  );

  inv_operand_regs inv_operand_regs_i (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .advance  (advance),
    .capture  (capture),
    .mont     (mont),
    .operand  (operand),
    .next_ops (next_ops),
    .ops      (ops),
    .result   (result)
  );

endmodule

/* project.f */
inv_pkg.sv
inv_iter_counter.sv
inv_control.sv
inv_step_unit.sv
inv_operand_regs.sv
mod_inv.sv
tb_mod_inv.sv

/* tb_mod_inv.sv */
`timescale 1ns/1ps

module tb_mod_inv;

  typedef enum logic [1:0] {
    kind_inverse,
    kind_mont,
    kind_zero
  } kind_t;

  // one row of the stimulus table
  typedef struct packed {
    inv_pkg::word_t operand;
    logic           mont;
    kind_t          kind;
    logic           inject;
  } entry_t;

  localparam int num_entries = 11;
  localparam int wait_limit = 1100;
  // load cycle, two cycles per iteration, finish cycle
  localparam int latency = 2 * inv_pkg::iter_count + 2;
  localparam int inject_cycle = 300;

  logic           clk;
  logic           reset;
  logic           start;
  logic           mont;
  inv_pkg::word_t operand;
  logic           busy;
  logic           done;
  inv_pkg::word_t result;

  entry_t stim_table [num_entries];
  int     mismatches;
  int     timeouts;
  int     idx;

  mod_inv mod_inv_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .mont    (mont),
    .operand (operand),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic check_word(input string name, input inv_pkg::word_t actual,
                            input inv_pkg::word_t expected);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_cycles(input string name, input int actual, input int expected);
    if (actual != expected) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, actual, expected);
    end
  endtask

  // full 512-bit product, then reduced by p
  function automatic inv_pkg::word_t mul_mod_p(input inv_pkg::word_t a,
                                               input inv_pkg::word_t b);
    logic [2*inv_pkg::word_w-1:0] prod;
    logic [2*inv_pkg::word_w-1:0] modulus;
    prod = {256'b0, a} * {256'b0, b};
    modulus = {256'b0, inv_pkg::prime};
    mul_mod_p = inv_pkg::word_t'(prod % modulus);
  endfunction

  // eight 32-bit draws, folded below p and kept non-zero
  function automatic inv_pkg::word_t random_word();
    inv_pkg::word_t w;
    int             i;
    for (i = 0; i < 8; i++) begin
      w[i*32 +: 32] = $urandom();
    end
    if (w >= inv_pkg::prime) begin
      w = w - inv_pkg::prime;
    end
    if (w == '0) begin
      w = inv_pkg::word_t'(1);
    end
    return w;
  endfunction

  function automatic entry_t make_entry(input inv_pkg::word_t op, input logic m,
                                        input kind_t k, input logic inj);
    entry_t e;
    e.operand = op;
    e.mont    = m;
    e.kind    = k;
    e.inject  = inj;
    return e;
  endfunction

  task automatic fill_table();
    int i;
    stim_table[0] = make_entry(inv_pkg::word_t'(1), 1'b0, kind_inverse, 1'b0);
    stim_table[1] = make_entry(inv_pkg::word_t'(2), 1'b0, kind_inverse, 1'b1);
    stim_table[2] = make_entry(inv_pkg::prime - 1'b1, 1'b1, kind_mont, 1'b0);
    // montgomery inverse of 2^256 mod p is 1
    stim_table[3] = make_entry(inv_pkg::mont_adjust, 1'b1, kind_mont, 1'b0);
    stim_table[4] = make_entry('0, 1'b0, kind_zero, 1'b0);
    for (i = 5; i < num_entries; i++) begin
      stim_table[i] = make_entry(random_word(), i[0], i[0] ? kind_mont : kind_inverse,
                                 i == 7);
    end
  endtask

  // one inversion from start to the cycle after done
  task automatic run_entry(input int n, input entry_t e);
    int             cycles;
    inv_pkg::word_t res;
    inv_pkg::word_t expected;
    @(negedge clk);
    operand = e.operand;
    mont    = e.mont;
    start   = 1'b1;
    @(negedge clk);
    start   = 1'b0;
    // inputs matter only at the start edge
    operand = ~e.operand;
    mont    = ~e.mont;
    cycles  = 0;
    while (!done && cycles < wait_limit) begin
      check_bit("busy", busy, 1'b1);
      @(negedge clk);
      cycles++;
      start = e.inject && (cycles == inject_cycle);
    end
    start = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout: entry %0d gave no done within %0d cycles", n, wait_limit);
    end else begin
      check_cycles("done latency", cycles, latency);
      check_bit("busy", busy, 1'b1);
      res = result;
      if (e.kind == kind_zero) begin
        check_word("result", res, '0);
      end else begin
        check_bit("result below p", res < inv_pkg::prime, 1'b1);
        expected = (e.kind == kind_mont) ? inv_pkg::mont_adjust : inv_pkg::word_t'(1);
        check_word("operand*result mod p", mul_mod_p(e.operand, res), expected);
      end
      @(negedge clk);
      check_bit("done", done, 1'b0);
      check_bit("busy", busy, 1'b0);
      check_word("result held", result, res);
    end
  endtask

  initial begin
    void'($urandom(32'h5e7f));
    mismatches = 0;
    timeouts   = 0;
    reset      = 1'b1;
    start      = 1'b0;
    mont       = 1'b0;
    operand    = '0;
    fill_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle after reset
    repeat (3) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("done", done, 1'b0);
    end

    idx = 0;
    while (idx < num_entries && timeouts == 0) begin
      run_entry(idx, stim_table[idx]);
      idx++;
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
